// File: rtl/dma_cfg.svh
//***********************************************************
// Buffer depth must stay a power of two matching buf_addr_t
// Select code 0 is unused and ignored by the register block
//***********************************************************
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

// Local buffer size in 32-bit words
`define DMA_BUF_DEPTH 512

// Host register select codes
`define DMA_SEL_BUS_ADDR 3'd1
`define DMA_SEL_BUF_ADDR 3'd2
`define DMA_SEL_BLOCK    3'd3
`define DMA_SEL_BURST    3'd4
`define DMA_SEL_CTRL     3'd5

// Bus is byte addressed, one word per step
`define DMA_ADDR_STEP 32'd4

`endif

// File: rtl/dma_pkg.sv
//***********************************************************
// Shared widths and the transfer state encoding
//***********************************************************
package dma_pkg;

    // Address or data word on the shared bus lines
    typedef logic [31:0] bus_word_t;

    // Word address into the local buffer
    typedef logic [8:0] buf_addr_t;

    // Block size in words, zero means nothing to move
    typedef logic [9:0] block_len_t;

    // Words per burst minus one, as sent on the bus
    typedef logic [7:0] burst_len_t;

    // Host register select
    typedef logic [2:0] reg_sel_t;

    typedef enum logic [2:0] {
        IDLE,
        REQUEST,
        BEGIN,
        WRITE_DATA,
        READ_DATA,
        END_BURST
    } dma_state_t;

endpackage

// File: rtl/dma_regs.sv
//***********************************************************
// Start is ignored while a transfer runs
// Error status is sticky until the next start
//***********************************************************
`timescale 1ns/1ps
`include "dma_cfg.svh"

module dma_regs (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  cfg_write,
    input  dma_pkg::reg_sel_t     cfg_select,
    input  dma_pkg::bus_word_t    cfg_data,
    input  logic                  transfer_busy,
    input  logic                  transfer_error,
    output dma_pkg::bus_word_t    bus_start_address,
    output dma_pkg::buf_addr_t    buf_start_address,
    output dma_pkg::block_len_t   block_size,
    output dma_pkg::burst_len_t   burst_size,
    output logic [1:0]            control_out,
    output logic [1:0]            status_out,
    output logic                  start
);
    import dma_pkg::*;

    logic error_q;

    // Register file, low bits of cfg_data are kept
    always_ff @(posedge clock) begin
        if (rst) begin
            bus_start_address <= '0;
            buf_start_address <= '0;
            block_size        <= '0;
            burst_size        <= '0;
            control_out       <= '0;
        end else if (cfg_write) begin
            case (cfg_select)
                `DMA_SEL_BUS_ADDR: bus_start_address <= cfg_data;
                `DMA_SEL_BUF_ADDR: buf_start_address <= buf_addr_t'(cfg_data);
                `DMA_SEL_BLOCK:    block_size <= block_len_t'(cfg_data);
                `DMA_SEL_BURST:    burst_size <= burst_len_t'(cfg_data);
                `DMA_SEL_CTRL:     control_out <= cfg_data[1:0];
                default: ;
            endcase
        end
    end

    // One cycle start pulse, blocked while busy or already starting
    always_ff @(posedge clock) begin
        if (rst) begin
            start <= 1'b0;
        end else begin
            start <= cfg_write && (cfg_select == `DMA_SEL_CTRL) && cfg_data[0]
                     && !transfer_busy && !start;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            error_q <= 1'b0;
        end else if (start) begin
            error_q <= 1'b0;
        end else if (transfer_error) begin
            error_q <= 1'b1;
        end
    end

    // Bit 1 error, bit 0 busy
    assign status_out = {error_q, transfer_busy};

    // FSM must not still be running when a new start arrives
    a_no_start_when_busy: assert property (
        @(posedge clock) disable iff (rst) start |-> !transfer_busy
    );

endmodule

// File: rtl/dma_burst_counter.sv
//***********************************************************
// buf_address is the look-ahead address for the buffer port
// Burst start must not be issued with an empty block
//***********************************************************
`timescale 1ns/1ps
`include "dma_cfg.svh"

module dma_burst_counter (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  load,
    input  logic                  burst_start,
    input  logic                  word_done,
    input  dma_pkg::bus_word_t    bus_start_address,
    input  dma_pkg::buf_addr_t    buf_start_address,
    input  dma_pkg::block_len_t   block_size,
    input  dma_pkg::burst_len_t   burst_size,
    output dma_pkg::burst_len_t   burst_length,
    output dma_pkg::bus_word_t    bus_address,
    output dma_pkg::buf_addr_t    buf_address,
    output logic                  last_word_in_burst,
    output logic                  block_done
);
    import dma_pkg::*;

    block_len_t words_left;
    block_len_t burst_count;
    block_len_t burst_plus;
    block_len_t next_burst;
    buf_addr_t  buf_addr_q;
    buf_addr_t  buf_next;

    // Burst is capped by what is left of the block
    assign burst_plus = block_len_t'(burst_size) + block_len_t'(1);
    assign next_burst = (burst_plus < words_left) ? burst_plus : words_left;

    always_ff @(posedge clock) begin
        if (rst) begin
            words_left  <= '0;
            burst_count <= '0;
        end else if (load) begin
            words_left  <= block_size;
            burst_count <= '0;
        end else if (burst_start) begin
            burst_count <= next_burst;
        end else if (word_done) begin
            words_left  <= words_left - block_len_t'(1);
            burst_count <= burst_count - block_len_t'(1);
        end
    end

    assign buf_next = (buf_addr_q == buf_addr_t'(`DMA_BUF_DEPTH - 1)) ? '0 : buf_addr_q + 1'b1;

    always_ff @(posedge clock) begin
        if (load) begin
            bus_address <= bus_start_address;
            buf_addr_q  <= buf_start_address;
        end else if (word_done) begin
            bus_address <= bus_address + `DMA_ADDR_STEP;
            buf_addr_q  <= buf_next;
        end
        if (burst_start) begin
            burst_length <= burst_len_t'(next_burst - block_len_t'(1));
        end
    end

    // Registered read in the buffer sees the address after this edge
    assign buf_address = word_done ? buf_next : buf_addr_q;

    assign last_word_in_burst = (burst_count == block_len_t'(1));
    assign block_done         = (words_left == '0);

    a_no_word_past_block: assert property (
        @(posedge clock) disable iff (rst) word_done |-> words_left != '0
    );

endmodule

// File: rtl/dma_fsm.sv
//***********************************************************
// Single bus master, one burst in flight, bus_busy only
// stalls write bursts; short read bursts are not handled
//***********************************************************
`timescale 1ns/1ps

module dma_fsm (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  start,
    input  logic                  direction,
    input  logic                  bus_grant,
    input  logic                  bus_busy,
    input  logic                  bus_error,
    input  logic                  bus_data_valid_in,
    input  logic                  bus_end_transaction_in,
    input  dma_pkg::bus_word_t    bus_address_data_in,
    input  dma_pkg::burst_len_t   burst_length,
    input  dma_pkg::bus_word_t    bus_address,
    input  logic                  last_word_in_burst,
    input  logic                  block_done,
    output logic                  buf_write,
    output dma_pkg::bus_word_t    buf_write_data,
    input  dma_pkg::bus_word_t    buf_read_data,
    output logic                  load,
    output logic                  burst_start,
    output logic                  word_done,
    output logic                  bus_request,
    output logic                  bus_begin_transaction,
    output dma_pkg::bus_word_t    bus_address_data_out,
    output dma_pkg::burst_len_t   bus_burst_size,
    output logic                  bus_read_n_write,
    output logic                  bus_data_valid_out,
    output logic                  bus_end_transaction_out,
    output logic                  transfer_busy,
    output logic                  transfer_error
);
    import dma_pkg::*;

    dma_state_t state;
    dma_state_t next_state;
    logic       dir_q;
    logic       rd_done_q;
    logic       in_burst;

    assign in_burst       = (state == BEGIN) || (state == WRITE_DATA) || (state == READ_DATA);
    assign transfer_error = bus_error && in_burst;
    assign transfer_busy  = (state != IDLE);

    always_comb begin
        next_state  = state;
        load        = 1'b0;
        burst_start = 1'b0;
        case (state)
            IDLE: begin
                if (start) begin
                    next_state = REQUEST;
                    load       = 1'b1;
                end
            end
            REQUEST: begin
                // Also the exit for a zero sized block
                if (block_done) begin
                    next_state = IDLE;
                end else if (bus_grant) begin
                    next_state  = BEGIN;
                    burst_start = 1'b1;
                end
            end
            BEGIN:      next_state = dir_q ? WRITE_DATA : READ_DATA;
            WRITE_DATA: begin
                if (!bus_busy && last_word_in_burst) begin
                    next_state = END_BURST;
                end
            end
            READ_DATA: begin
                if (bus_end_transaction_in) begin
                    next_state = END_BURST;
                end
            end
            END_BURST:  next_state = REQUEST;
            default:    next_state = IDLE;
        endcase
        if (transfer_error) begin
            next_state = IDLE;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state     <= IDLE;
            dir_q     <= 1'b0;
            rd_done_q <= 1'b0;
        end else begin
            state     <= next_state;
            rd_done_q <= (state == READ_DATA) && bus_data_valid_in;
            if (load) begin
                dir_q <= direction;
            end
        end
    end

    // Read words are counted a cycle late so the write address stays put
    assign word_done = ((state == WRITE_DATA) && !bus_busy) || rd_done_q;

    assign buf_write      = (state == READ_DATA) && bus_data_valid_in;
    assign buf_write_data = bus_address_data_in;

    // Request drops in END_BURST to free the bus between bursts
    assign bus_request = in_burst || ((state == REQUEST) && !block_done);

    assign bus_begin_transaction   = (state == BEGIN);
    assign bus_burst_size          = (state == BEGIN) ? burst_length : '0;
    assign bus_read_n_write        = (state == BEGIN) && !dir_q;
    assign bus_data_valid_out      = (state == WRITE_DATA);
    assign bus_end_transaction_out = (state == END_BURST) && dir_q;

    always_comb begin
        case (state)
            BEGIN:      bus_address_data_out = bus_address;
            WRITE_DATA: bus_address_data_out = buf_read_data;
            default:    bus_address_data_out = '0;
        endcase
    end

    a_begin_after_grant: assert property (
        @(posedge clock) disable iff (rst) bus_begin_transaction |-> $past(bus_grant)
    );

    // Write data starts right after the command and runs without gaps
    a_valid_in_write_burst: assert property (
        @(posedge clock) disable iff (rst)
        bus_data_valid_out |-> (state == WRITE_DATA)
            && ($past(bus_begin_transaction) || $past(bus_data_valid_out))
    );

endmodule

// File: rtl/dma_buffer.sv
//***********************************************************
// Both ports read old data on a same-address write
// DMA write wins when both ports write one address
//***********************************************************
`timescale 1ns/1ps
`include "dma_cfg.svh"

module dma_buffer (
    input  logic                  clock,
    input  logic                  host_write,
    input  dma_pkg::buf_addr_t    host_address,
    input  dma_pkg::bus_word_t    host_write_data,
    output dma_pkg::bus_word_t    host_read_data,
    input  logic                  dma_write,
    input  dma_pkg::buf_addr_t    dma_address,
    input  dma_pkg::bus_word_t    dma_write_data,
    output dma_pkg::bus_word_t    dma_read_data
);
    import dma_pkg::*;

    bus_word_t mem [`DMA_BUF_DEPTH];

    always_ff @(posedge clock) begin
        if (host_write) begin
            mem[host_address] <= host_write_data;
        end
        if (dma_write) begin
            mem[dma_address] <= dma_write_data;
        end
        // Registered reads, one cycle latency on each port
        host_read_data <= mem[host_address];
        dma_read_data  <= mem[dma_address];
    end

endmodule

// File: rtl/dma_top.sv
//***********************************************************
// Host side runs on the same clock as the bus
//***********************************************************
`timescale 1ns/1ps

module dma_top (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  cfg_write,
    input  dma_pkg::reg_sel_t     cfg_select,
    input  dma_pkg::bus_word_t    cfg_data,
    input  logic                  host_buf_write,
    input  dma_pkg::buf_addr_t    host_buf_address,
    input  dma_pkg::bus_word_t    host_buf_write_data,
    output dma_pkg::bus_word_t    host_buf_read_data,
    output logic                  bus_request,
    input  logic                  bus_grant,
    output logic                  bus_begin_transaction,
    output dma_pkg::bus_word_t    bus_address_data_out,
    output dma_pkg::burst_len_t   bus_burst_size,
    output logic                  bus_read_n_write,
    output logic                  bus_data_valid_out,
    output logic                  bus_end_transaction_out,
    input  dma_pkg::bus_word_t    bus_address_data_in,
    input  logic                  bus_data_valid_in,
    input  logic                  bus_end_transaction_in,
    input  logic                  bus_busy,
    input  logic                  bus_error,
    output dma_pkg::bus_word_t    bus_start_address_out,
    output dma_pkg::buf_addr_t    buf_start_address_out,
    output dma_pkg::block_len_t   block_size_out,
    output dma_pkg::burst_len_t   burst_size_out,
    output logic [1:0]            control_out,
    output logic [1:0]            status_out
);
    import dma_pkg::*;

    logic       start;
    logic       transfer_busy;
    logic       transfer_error;
    logic       load;
    logic       burst_start;
    logic       word_done;
    logic       last_word_in_burst;
    logic       block_done;
    logic       buf_write;
    burst_len_t burst_length;
    bus_word_t  bus_address;
    buf_addr_t  buf_address;
    bus_word_t  buf_write_data;
    bus_word_t  buf_read_data;

    dma_regs regs_i (
        .clock             (clock),
        .rst               (rst),
        .cfg_write         (cfg_write),
        .cfg_select        (cfg_select),
        .cfg_data          (cfg_data),
        .transfer_busy     (transfer_busy),
        .transfer_error    (transfer_error),
        .bus_start_address (bus_start_address_out),
        .buf_start_address (buf_start_address_out),
        .block_size        (block_size_out),
        .burst_size        (burst_size_out),
        .control_out       (control_out),
        .status_out        (status_out),
        .start             (start)
    );

    dma_burst_counter counter_i (
        .clock              (clock),
        .rst                (rst),
        .load               (load),
        .burst_start        (burst_start),
        .word_done          (word_done),
        .bus_start_address  (bus_start_address_out),
        .buf_start_address  (buf_start_address_out),
        .block_size         (block_size_out),
        .burst_size         (burst_size_out),
        .burst_length       (burst_length),
        .bus_address        (bus_address),
        .buf_address        (buf_address),
        .last_word_in_burst (last_word_in_burst),
        .block_done         (block_done)
    );

    // Control bit 1 selects buffer to bus
    dma_fsm fsm_i (
        .clock                   (clock),
        .rst                     (rst),
        .start                   (start),
        .direction               (control_out[1]),
        .bus_grant               (bus_grant),
        .bus_busy                (bus_busy),
        .bus_error               (bus_error),
        .bus_data_valid_in       (bus_data_valid_in),
        .bus_end_transaction_in  (bus_end_transaction_in),
        .bus_address_data_in     (bus_address_data_in),
        .burst_length            (burst_length),
        .bus_address             (bus_address),
        .last_word_in_burst      (last_word_in_burst),
        .block_done              (block_done),
        .buf_write               (buf_write),
        .buf_write_data          (buf_write_data),
        .buf_read_data           (buf_read_data),
        .load                    (load),
        .burst_start             (burst_start),
        .word_done               (word_done),
        .bus_request             (bus_request),
        .bus_begin_transaction   (bus_begin_transaction),
        .bus_address_data_out    (bus_address_data_out),
        .bus_burst_size          (bus_burst_size),
        .bus_read_n_write        (bus_read_n_write),
        .bus_data_valid_out      (bus_data_valid_out),
        .bus_end_transaction_out (bus_end_transaction_out),
        .transfer_busy           (transfer_busy),
        .transfer_error          (transfer_error)
    );

    dma_buffer buffer_i (
        .clock           (clock),
        .host_write      (host_buf_write),
        .host_address    (host_buf_address),
        .host_write_data (host_buf_write_data),
        .host_read_data  (host_buf_read_data),
        .dma_write       (buf_write),
        .dma_address     (buf_address),
        .dma_write_data  (buf_write_data),
        .dma_read_data   (buf_read_data)
    );

endmodule

// File: tests/bus_slave_model.sv
//***********************************************************
// Bus target with 1024 words of memory, byte address bits 11:2
// Records up to 64 commands; errors come from the testbench
//***********************************************************
`timescale 1ns/1ps

module bus_slave_model (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  bus_request,
    input  logic                  bus_begin_transaction,
    input  dma_pkg::bus_word_t    bus_address_data_out,
    input  dma_pkg::burst_len_t   bus_burst_size,
    input  logic                  bus_read_n_write,
    input  logic                  bus_data_valid_out,
    input  logic                  bus_end_transaction_out,
    input  logic                  bus_error,
    output logic                  bus_grant,
    output dma_pkg::bus_word_t    bus_address_data_in,
    output logic                  bus_data_valid_in,
    output logic                  bus_end_transaction_in,
    output logic                  bus_busy
);
    import dma_pkg::*;

    bus_word_t  mem [1024];
    bus_word_t  cmd_addr [64];
    burst_len_t cmd_size [64];
    int         cmd_count;
    int         seed;
    int         grant_wait;
    int         read_left;
    bus_word_t  ptr;
    logic       write_active;

    // Fill pattern mixes every address bit
    initial begin
        seed = 32'h932e5808;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = (i * 32'h0001_0003) ^ 32'hc3a5_0000;
        end
    end

    always @(posedge clock) begin
        if (rst) begin
            bus_grant              <= 1'b0;
            bus_busy               <= 1'b0;
            bus_data_valid_in      <= 1'b0;
            bus_end_transaction_in <= 1'b0;
            bus_address_data_in    <= '0;
            grant_wait   = 0;
            read_left    = 0;
            write_active = 1'b0;
            cmd_count    = 0;
        end else begin
            // Random grant delay, grant drops with the request
            if (!bus_request) begin
                bus_grant <= 1'b0;
                grant_wait = $random(seed) & 7;
            end else if (grant_wait > 0) begin
                grant_wait = grant_wait - 1;
            end else begin
                bus_grant <= 1'b1;
            end
            if (bus_begin_transaction) begin
                if (cmd_count < 64) begin
                    cmd_addr[cmd_count] = bus_address_data_out;
                    cmd_size[cmd_count] = bus_burst_size;
                end
                cmd_count = cmd_count + 1;
                ptr = bus_address_data_out;
                if (bus_read_n_write) begin
                    read_left = int'(bus_burst_size) + 1;
                end else begin
                    write_active = 1'b1;
                end
            end
            if (bus_data_valid_out && !bus_busy) begin
                mem[ptr[11:2]] <= bus_address_data_out;
                ptr = ptr + 32'd4;
            end
            if (bus_end_transaction_out || bus_error) begin
                write_active = 1'b0;
            end
            if (bus_error) begin
                read_left = 0;
            end
            bus_busy <= write_active && (($random(seed) & 3) == 0);
            // Read data back to back, end marked on the last word
            if (read_left > 0) begin
                bus_address_data_in    <= mem[ptr[11:2]];
                bus_data_valid_in      <= 1'b1;
                bus_end_transaction_in <= (read_left == 1);
                ptr = ptr + 32'd4;
                read_left = read_left - 1;
            end else begin
                bus_data_valid_in      <= 1'b0;
                bus_end_transaction_in <= 1'b0;
            end
        end
    end

endmodule

// File: tests/dma_tb.sv
//***********************************************************
// Bus addresses must stay below 4 KB for the bus model
//***********************************************************
`timescale 1ns/1ps
`include "dma_cfg.svh"

module dma_tb;
    import dma_pkg::*;

    logic clock;
    logic rst;
    logic cfg_write;
    reg_sel_t cfg_select;
    bus_word_t cfg_data;
    logic host_buf_write;
    buf_addr_t host_buf_address;
    bus_word_t host_buf_write_data;
    bus_word_t host_buf_read_data;
    logic bus_request;
    logic bus_grant;
    logic bus_begin_transaction;
    bus_word_t bus_address_data_out;
    burst_len_t bus_burst_size;
    logic bus_read_n_write;
    logic bus_data_valid_out;
    logic bus_end_transaction_out;
    bus_word_t bus_address_data_in;
    logic bus_data_valid_in;
    logic bus_end_transaction_in;
    logic bus_busy;
    logic bus_error;
    bus_word_t bus_start_address_out;
    buf_addr_t buf_start_address_out;
    block_len_t block_size_out;
    burst_len_t burst_size_out;
    logic [1:0] control_out;
    logic [1:0] status_out;

    int seed;
    int errors;
    int cmd_base;
    bus_word_t exp_buf [512];

    // Four transfers of 205 words in all
    localparam int WATCHDOG_CYCLES = 205 * 20 + 2000;

    dma_top dma_top_i (.*);

    bus_slave_model slave_i (.*);

    always #4 clock = ~clock;

    task automatic note_mismatch(input string msg);
        errors = errors + 1;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    a_bus_addr_reg: assert property (@(posedge clock) disable iff (rst)
        cfg_write && cfg_select == `DMA_SEL_BUS_ADDR |=> bus_start_address_out == $past(cfg_data))
        else note_mismatch("bus start address register");
    a_buf_addr_reg: assert property (@(posedge clock) disable iff (rst)
        cfg_write && cfg_select == `DMA_SEL_BUF_ADDR
        |=> buf_start_address_out == $past(cfg_data[8:0]))
        else note_mismatch("buffer start address register");
    a_block_reg: assert property (@(posedge clock) disable iff (rst)
        cfg_write && cfg_select == `DMA_SEL_BLOCK |=> block_size_out == $past(cfg_data[9:0]))
        else note_mismatch("block size register");
    a_burst_reg: assert property (@(posedge clock) disable iff (rst)
        cfg_write && cfg_select == `DMA_SEL_BURST |=> burst_size_out == $past(cfg_data[7:0]))
        else note_mismatch("burst size register");
    a_ctrl_reg: assert property (@(posedge clock) disable iff (rst)
        cfg_write && cfg_select == `DMA_SEL_CTRL |=> control_out == $past(cfg_data[1:0]))
        else note_mismatch("control register");
    // Held word under busy
    a_busy_hold: assert property (@(posedge clock) disable iff (rst)
        bus_data_valid_out && bus_busy && !bus_error
        |=> bus_data_valid_out && $stable(bus_address_data_out))
        else note_mismatch("write word not held under busy");
    // End pulse right after the last accepted write word
    a_write_end: assert property (@(posedge clock) disable iff (rst)
        bus_data_valid_out && !bus_busy && !bus_error
        |=> bus_data_valid_out != bus_end_transaction_out)
        else note_mismatch("write burst not closed by end pulse");
    a_end_after_word: assert property (@(posedge clock) disable iff (rst)
        bus_end_transaction_out |-> $past(bus_data_valid_out && !bus_busy))
        else note_mismatch("end pulse without a last write word");
    a_error_drops_request: assert property (@(posedge clock) disable iff (rst)
        $rose(status_out[1]) |-> !bus_request)
        else note_mismatch("bus_request still high after bus error");
    a_no_begin_after_error: assert property (@(posedge clock) disable iff (rst)
        status_out[1] |-> !bus_begin_transaction)
        else note_mismatch("begin pulse after bus error");

    task automatic write_reg(input reg_sel_t sel, input bus_word_t value);
        @(posedge clock);
        cfg_write  <= 1'b1;
        cfg_select <= sel;
        cfg_data   <= value;
        @(posedge clock);
        cfg_write  <= 1'b0;
    endtask

    task automatic run_transfer(input bus_word_t bus_addr, input int buf_addr,
                                input int block, input int burst, input logic to_bus);
        write_reg(`DMA_SEL_BUS_ADDR, bus_addr);
        write_reg(`DMA_SEL_BUF_ADDR, bus_word_t'(buf_addr));
        write_reg(`DMA_SEL_BLOCK, bus_word_t'(block));
        write_reg(`DMA_SEL_BURST, bus_word_t'(burst));
        cmd_base = slave_i.cmd_count;
        write_reg(`DMA_SEL_CTRL, {30'd0, to_bus, 1'b1});
        @(negedge clock);
        while (!status_out[0]) @(negedge clock);
        assert (status_out[1] == 1'b0) else note_mismatch("error bit not cleared by start");
        while (status_out[0]) @(negedge clock);
    endtask

    task automatic check_bursts(input bus_word_t bus_addr, input int block, input int burst);
        int n;
        int left;
        int len;
        n = (block + burst) / (burst + 1);
        assert (slave_i.cmd_count - cmd_base == n) else note_mismatch("burst count");
        for (int i = 0; i < n && cmd_base + i < slave_i.cmd_count; i++) begin
            left = block - i * (burst + 1);
            len = (left < burst + 1) ? left : burst + 1;
            assert (int'(slave_i.cmd_size[cmd_base + i]) == len - 1)
                else note_mismatch("burst size on command");
            assert (slave_i.cmd_addr[cmd_base + i] == bus_addr + bus_word_t'(4 * i * (burst + 1)))
                else note_mismatch("burst address on command");
        end
    endtask

    task automatic check_bus_data(input bus_word_t bus_addr, input int buf_addr, input int block);
        for (int i = 0; i < block; i++) begin
            assert (slave_i.mem[(int'(bus_addr >> 2) + i) % 1024] == exp_buf[(buf_addr + i) % 512])
                else note_mismatch($sformatf("bus word %0d after buffer to bus", i));
        end
    endtask

    task automatic check_buf_data(input bus_word_t bus_addr, input int buf_addr, input int block);
        for (int i = 0; i < block; i++) begin
            @(posedge clock);
            host_buf_address <= buf_addr_t'((buf_addr + i) % 512);
            @(posedge clock);
            @(negedge clock);
            assert (host_buf_read_data == slave_i.mem[(int'(bus_addr >> 2) + i) % 1024])
                else note_mismatch($sformatf("buffer word %0d after bus to buffer", i));
        end
    endtask

    task automatic inject_error();
        @(negedge clock);
        while (!bus_begin_transaction) @(negedge clock);
        repeat ($random(seed) & 1) @(posedge clock);
        @(posedge clock);
        bus_error <= 1'b1;
        @(posedge clock);
        bus_error <= 1'b0;
    endtask

    initial begin
        #(WATCHDOG_CYCLES * 8);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        seed = 32'h932e5808;
        errors = 0;
        clock = 1'b0;
        rst = 1'b1;
        cfg_write = 1'b0;
        cfg_select = '0;
        cfg_data = '0;
        host_buf_write = 1'b0;
        host_buf_address = '0;
        host_buf_write_data = '0;
        bus_error = 1'b0;
        repeat (5) @(posedge clock);
        rst <= 1'b0;
        @(negedge clock);
        assert (status_out == 2'b00) else note_mismatch("status not zero after reset");
        for (int i = 0; i < 512; i++) begin
            @(posedge clock);
            exp_buf[i] = $random(seed);
            host_buf_write      <= 1'b1;
            host_buf_address    <= buf_addr_t'(i);
            host_buf_write_data <= exp_buf[i];
        end
        @(posedge clock);
        host_buf_write <= 1'b0;
        // Buffer start near the top so the address wraps
        run_transfer(32'h100, 500, 40, 7, 1'b1);
        check_bursts(32'h100, 40, 7);
        check_bus_data(32'h100, 500, 40);
        run_transfer(32'h800, 100, 37, 15, 1'b0);
        check_bursts(32'h800, 37, 15);
        check_buf_data(32'h800, 100, 37);
        fork
            inject_error();
            run_transfer(32'h400, 200, 64, 31, 1'b1);
        join
        assert (status_out[1] == 1'b1) else note_mismatch("error bit not set");
        run_transfer(32'h400, 200, 64, 31, 1'b1);
        check_bursts(32'h400, 64, 31);
        check_bus_data(32'h400, 200, 64);
        $display("Checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+rtl
rtl/dma_pkg.sv
rtl/dma_regs.sv
rtl/dma_burst_counter.sv
rtl/dma_fsm.sv
rtl/dma_buffer.sv
rtl/dma_top.sv
tests/bus_slave_model.sv
tests/dma_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f filelist.f --top-module dma_tb -o Vdma_tb \
    && ./obj_dir/Vdma_tb | tee /dev/stderr | grep -q "^STATUS: PASS$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
